/* rtl/fft64_pkg.sv */
`default_nettype none

package fft64_pkg;

   localparam int n_points = 64;
   localparam int addr_w   = 6;
   localparam int part_w   = 11;
   localparam int sample_w = 2 * part_w;  // re in upper half
   localparam int tw_w     = 12;
   localparam int tw_frac  = 10;
   localparam int bus_aw   = 7;
   localparam int bus_dw   = 32;

   localparam logic [bus_aw-1:0] ctrl_addr = 7'd64;

   // first quarter of cos(2*pi*k/64) * 1024, k = 0..16
   localparam logic signed [tw_w-1:0] cos_tab [0:16] = '{
      1024, 1019, 1004, 980, 946, 903, 851, 792, 724,
      650, 569, 483, 392, 297, 200, 100, 0};

   typedef logic [sample_w-1:0] sample_t;

   typedef enum logic [1:0] {
      pass_stride16,
      pass_stride4,
      pass_stride1
   } fft_pass_t;

   function automatic logic signed [tw_w-1:0] twiddle_re(input logic [addr_w-1:0] e);
      logic [4:0] r;
      r = {1'b0, e[3:0]};
      case (e[5:4])  // quadrant
         2'd0: return cos_tab[r];
         2'd1: return -cos_tab[5'd16 - r];
         2'd2: return -cos_tab[r];
         default: return cos_tab[5'd16 - r];
      endcase
   endfunction

   // negated sine
   function automatic logic signed [tw_w-1:0] twiddle_im(input logic [addr_w-1:0] e);
      logic [4:0] r;
      r = {1'b0, e[3:0]};
      case (e[5:4])
         2'd0: return -cos_tab[5'd16 - r];
         2'd1: return -cos_tab[r];
         2'd2: return cos_tab[5'd16 - r];
         default: return cos_tab[r];
      endcase
   endfunction

   function automatic logic [addr_w-1:0] digit_rev(input logic [addr_w-1:0] i);
      return {i[1:0], i[3:2], i[5:4]};  // three base-4 digits
   endfunction

endpackage

`default_nettype wire

/* rtl/fft_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_wb_regs import fft64_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  logic [bus_aw-1:0] adr,
   input  logic [bus_dw-1:0] dat_w,
   output logic [bus_dw-1:0] dat_r,
   output logic              ack,
   output logic              buf_we,
   output logic [addr_w-1:0] buf_addr,
   output sample_t           buf_wdata,
   input  sample_t           buf_rdata,
   output logic              go,
   input  logic              busy,
   input  logic              finish
);

   logic              req;
   logic              sample_sel;
   logic              ctrl_sel;
   logic              done;
   logic [bus_dw-1:0] rd_word;

   assign req        = cyc && stb && !ack;  // one ack per request
   assign sample_sel = (adr[bus_aw-1] == 1'b0);  // lower half is samples
   assign ctrl_sel   = (adr == ctrl_addr);

   assign buf_we    = req && we && sample_sel && !busy;
   assign buf_addr  = adr[addr_w-1:0];
   assign buf_wdata = dat_w[sample_w-1:0];

   always_comb begin
      rd_word = '0;
      if (sample_sel) begin
         rd_word[sample_w-1:0] = buf_rdata;  // already digit reversed
      end else if (ctrl_sel) begin
         rd_word[1:0] = {done, busy};
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         ack  <= 1'b0;
         go   <= 1'b0;
         done <= 1'b0;
      end else begin
         ack <= req;
         go  <= req && we && ctrl_sel && dat_w[0] && !busy;
         if (go) begin
            done <= 1'b0;
         end else if (finish) begin
            done <= 1'b1;  // sticky until next start
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req && !we) begin
         dat_r <= rd_word;
      end
   end

endmodule

`default_nettype wire

/* rtl/sample_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_buffer import fft64_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              buf_we,
   input  logic [addr_w-1:0] buf_addr,
   input  sample_t           buf_wdata,
   output sample_t           buf_rdata,
   input  logic [addr_w-1:0] rd_addr0,
   input  logic [addr_w-1:0] rd_addr1,
   input  logic [addr_w-1:0] rd_addr2,
   input  logic [addr_w-1:0] rd_addr3,
   output sample_t           rd_data0,
   output sample_t           rd_data1,
   output sample_t           rd_data2,
   output sample_t           rd_data3,
   input  logic              eng_we,
   input  logic [addr_w-1:0] wr_addr0,
   input  logic [addr_w-1:0] wr_addr1,
   input  logic [addr_w-1:0] wr_addr2,
   input  logic [addr_w-1:0] wr_addr3,
   input  sample_t           wr_data0,
   input  sample_t           wr_data1,
   input  sample_t           wr_data2,
   input  sample_t           wr_data3
);

   sample_t mem [n_points];

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 0; i < n_points; i++) begin
            mem[i] <= '0;
         end
      end else if (eng_we) begin
         mem[wr_addr0] <= wr_data0;  // four distinct addresses per group
         mem[wr_addr1] <= wr_data1;
         mem[wr_addr2] <= wr_data2;
         mem[wr_addr3] <= wr_data3;
      end else if (buf_we) begin
         mem[buf_addr] <= buf_wdata;
      end
   end

   assign buf_rdata = mem[digit_rev(buf_addr)];  // natural order for the bus
   assign rd_data0  = mem[rd_addr0];
   assign rd_data1  = mem[rd_addr1];
   assign rd_data2  = mem[rd_addr2];
   assign rd_data3  = mem[rd_addr3];

endmodule

`default_nettype wire

/* rtl/fft_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module fft_sequencer import fft64_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              go,
   output logic              busy,
   output logic              finish,
   output logic [addr_w-1:0] rd_addr0,
   output logic [addr_w-1:0] rd_addr1,
   output logic [addr_w-1:0] rd_addr2,
   output logic [addr_w-1:0] rd_addr3,
   output logic [addr_w-1:0] wr_addr0,
   output logic [addr_w-1:0] wr_addr1,
   output logic [addr_w-1:0] wr_addr2,
   output logic [addr_w-1:0] wr_addr3,
   output logic              eng_we,
   output logic              in_valid,
   output logic [addr_w-1:0] exp,
   output logic [3:0]        tag,
   input  logic              out_valid,
   input  logic [3:0]        out_tag
);

   fft_pass_t  pass;
   logic [3:0] grp;
   logic       issuing;
   logic [3:0] wb_cnt;

   // base + lane * stride as index bit fields
   function automatic logic [addr_w-1:0] lane_addr(input fft_pass_t p,
                                                   input logic [3:0] g,
                                                   input logic [1:0] lane);
      case (p)
         pass_stride16: return {lane, g};
         pass_stride4: return {g[3:2], lane, g[1:0]};
         default: return {g, lane};
      endcase
   endfunction

   assign rd_addr0 = lane_addr(pass, grp, 2'd0);
   assign rd_addr1 = lane_addr(pass, grp, 2'd1);
   assign rd_addr2 = lane_addr(pass, grp, 2'd2);
   assign rd_addr3 = lane_addr(pass, grp, 2'd3);

   // write back where the group was read
   assign wr_addr0 = lane_addr(pass, out_tag, 2'd0);
   assign wr_addr1 = lane_addr(pass, out_tag, 2'd1);
   assign wr_addr2 = lane_addr(pass, out_tag, 2'd2);
   assign wr_addr3 = lane_addr(pass, out_tag, 2'd3);

   assign eng_we   = out_valid && busy;
   assign in_valid = issuing;
   assign tag      = grp;

   always_comb begin
      case (pass)
         pass_stride16: exp = {2'b00, grp};
         pass_stride4: exp = {2'b00, grp[1:0], 2'b00};
         default: exp = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         busy    <= 1'b0;
         finish  <= 1'b0;
         pass    <= pass_stride16;
         grp     <= '0;
         issuing <= 1'b0;
         wb_cnt  <= '0;
      end else begin
         finish <= 1'b0;
         if (go && !busy) begin
            busy    <= 1'b1;
            pass    <= pass_stride16;
            grp     <= '0;
            issuing <= 1'b1;
            wb_cnt  <= '0;
         end
         if (issuing) begin
            grp <= grp + 4'd1;  // wraps to 0 for the next pass
            if (grp == 4'd15) begin
               issuing <= 1'b0;
            end
         end
         if (eng_we) begin
            wb_cnt <= wb_cnt + 4'd1;
            if (wb_cnt == 4'd15) begin  // pass drained
               if (pass == pass_stride1) begin
                  busy   <= 1'b0;
                  finish <= 1'b1;
               end else begin
                  pass    <= (pass == pass_stride16) ? pass_stride4 : pass_stride1;
                  issuing <= 1'b1;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

/* rtl/radix4_butterfly.sv */
`timescale 1ns/1ps
`default_nettype none

module radix4_butterfly import fft64_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              in_valid,
   input  sample_t           x0,
   input  sample_t           x1,
   input  sample_t           x2,
   input  sample_t           x3,
   input  logic [addr_w-1:0] exp,
   input  logic [3:0]        tag,
   output logic              out_valid,
   output sample_t           y0,
   output sample_t           y1,
   output sample_t           y2,
   output sample_t           y3,
   output logic [3:0]        out_tag
);

   logic signed [part_w-1:0] s1_re [4];
   logic signed [part_w-1:0] s1_im [4];
   logic [addr_w-1:0]        s1_exp;
   logic [3:0]               s1_tag;
   logic                     s1_valid;
   logic signed [part_w:0]   sum_re [4];
   logic signed [part_w:0]   sum_im [4];
   logic signed [part_w:0]   s2_re [4];
   logic signed [part_w:0]   s2_im [4];
   logic [addr_w-1:0]        s2_exp;
   logic [3:0]               s2_tag;
   logic                     s2_valid;
   logic signed [part_w-1:0] y_re [4];
   logic signed [part_w-1:0] y_im [4];

   always_ff @(posedge clk) begin
      s1_re[0] <= x0[sample_w-1:part_w];
      s1_im[0] <= x0[part_w-1:0];
      s1_re[1] <= x1[sample_w-1:part_w];
      s1_im[1] <= x1[part_w-1:0];
      s1_re[2] <= x2[sample_w-1:part_w];
      s1_im[2] <= x2[part_w-1:0];
      s1_re[3] <= x3[sample_w-1:part_w];
      s1_im[3] <= x3[part_w-1:0];
      s1_exp   <= exp;
      s1_tag   <= tag;
      s2_re    <= sum_re;
      s2_im    <= sum_im;
      s2_exp   <= s1_exp;
      s2_tag   <= s1_tag;
      y0       <= {y_re[0], y_im[0]};
      y1       <= {y_re[1], y_im[1]};
      y2       <= {y_re[2], y_im[2]};
      y3       <= {y_re[3], y_im[3]};
      out_tag  <= s2_tag;
   end

   // y_m = sum x_n * (-j)^(n*m), then divide by 4
   always_comb begin
      logic signed [part_w+2:0] acc_re;
      logic signed [part_w+2:0] acc_im;
      for (int m = 0; m < 4; m++) begin
         acc_re = '0;
         acc_im = '0;
         for (int n = 0; n < 4; n++) begin
            case ((n * m) % 4)
               0: begin
                  acc_re += s1_re[n];
                  acc_im += s1_im[n];
               end
               1: begin  // times -j
                  acc_re += s1_im[n];
                  acc_im -= s1_re[n];
               end
               2: begin
                  acc_re -= s1_re[n];
                  acc_im -= s1_im[n];
               end
               default: begin  // times +j
                  acc_re -= s1_im[n];
                  acc_im += s1_re[n];
               end
            endcase
         end
         sum_re[m] = acc_re[part_w+2:2];
         sum_im[m] = acc_im[part_w+2:2];
      end
   end

   always_comb begin
      logic [addr_w-1:0]        tw_e;
      logic signed [tw_w-1:0]   w_re;
      logic signed [tw_w-1:0]   w_im;
      logic signed [2*tw_w:0]   p_re;
      logic signed [2*tw_w:0]   p_im;
      for (int m = 0; m < 4; m++) begin
         tw_e = s2_exp * addr_w'(m);  // mod 64
         w_re = twiddle_re(tw_e);
         w_im = twiddle_im(tw_e);
         p_re = s2_re[m] * w_re - s2_im[m] * w_im;
         p_im = s2_re[m] * w_im + s2_im[m] * w_re;
         y_re[m] = p_re[tw_frac+part_w-1:tw_frac];  // >>> 10, wrap
         y_im[m] = p_im[tw_frac+part_w-1:tw_frac];
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         s1_valid  <= 1'b0;
         s2_valid  <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         s1_valid  <= in_valid;
         s2_valid  <= s1_valid;
         out_valid <= s2_valid;
      end
   end

endmodule

`default_nettype wire

/* rtl/fft64_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fft64_top import fft64_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  logic [bus_aw-1:0] adr,
   input  logic [bus_dw-1:0] dat_w,
   output logic [bus_dw-1:0] dat_r,
   output logic              ack
);

   logic              buf_we;
   logic [addr_w-1:0] buf_addr;
   sample_t           buf_wdata;
   sample_t           buf_rdata;
   logic              go;
   logic              busy;
   logic              finish;
   logic [addr_w-1:0] rd_addr0, rd_addr1, rd_addr2, rd_addr3;
   logic [addr_w-1:0] wr_addr0, wr_addr1, wr_addr2, wr_addr3;
   sample_t           rd_data0, rd_data1, rd_data2, rd_data3;
   sample_t           y0, y1, y2, y3;
   logic              eng_we;
   logic              in_valid;
   logic              out_valid;
   logic [addr_w-1:0] exp;
   logic [3:0]        tag;
   logic [3:0]        out_tag;

   fft_wb_regs i_regs (
      .clk, .rst, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
      .buf_we, .buf_addr, .buf_wdata, .buf_rdata,
      .go, .busy, .finish
   );

   sample_buffer i_buf (
      .clk, .rst, .buf_we, .buf_addr, .buf_wdata, .buf_rdata,
      .rd_addr0, .rd_addr1, .rd_addr2, .rd_addr3,
      .rd_data0, .rd_data1, .rd_data2, .rd_data3,
      .eng_we, .wr_addr0, .wr_addr1, .wr_addr2, .wr_addr3,
      .wr_data0(y0), .wr_data1(y1), .wr_data2(y2), .wr_data3(y3)
   );

   fft_sequencer i_seq (
      .clk, .rst, .go, .busy, .finish,
      .rd_addr0, .rd_addr1, .rd_addr2, .rd_addr3,
      .wr_addr0, .wr_addr1, .wr_addr2, .wr_addr3,
      .eng_we, .in_valid, .exp, .tag, .out_valid, .out_tag
   );

   radix4_butterfly i_bfly (
      .clk, .rst, .in_valid,
      .x0(rd_data0), .x1(rd_data1), .x2(rd_data2), .x3(rd_data3),
      .exp, .tag, .out_valid, .y0, .y1, .y2, .y3, .out_tag
   );

endmodule

`default_nettype wire

/* bench/fft64_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fft64_tb import fft64_pkg::*; ();

   localparam int ack_timeout  = 20;
   localparam int done_timeout = 200;

   logic              clk;
   logic              rst;
   logic              cyc;
   logic              stb;
   logic              we;
   logic [bus_aw-1:0] adr;
   logic [bus_dw-1:0] dat_w;
   logic [bus_dw-1:0] dat_r;
   logic              ack;

   logic [15:0] lfsr;
   int          model_re [n_points];
   int          model_im [n_points];
   int          errors;
   int          test_errors;
   int          tests_run;
   int          tests_failed;

   fft64_top i_dut (.clk, .rst, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack);

   always #5 clk = ~clk;

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);  // x^16+x^14+x^13+x^11+1
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic int wrap_part(input int v);
      logic signed [part_w-1:0] t;
      t = v[part_w-1:0];
      return int'(t);
   endfunction

   function automatic logic [bus_dw-1:0] pack_parts(input int re, input int im);
      return {10'd0, re[part_w-1:0], im[part_w-1:0]};
   endfunction

   function automatic logic [bus_dw-1:0] model_word(input int a);
      return pack_parts(model_re[a], model_im[a]);
   endfunction

   task automatic set_model(input int a, input logic [sample_w-1:0] s);
      model_re[a] = wrap_part(int'(s[sample_w-1:part_w]));
      model_im[a] = wrap_part(int'(s[part_w-1:0]));
   endtask

   // one radix-4 group written back in place
   task automatic model_group(input int base, input int stride, input int e);
      int xr [4];
      int xi [4];
      int sr;
      int si;
      int rr;
      int ri;
      int t;
      int wr;
      int wi;
      for (int n = 0; n < 4; n++) begin
         xr[n] = model_re[base + n * stride];
         xi[n] = model_im[base + n * stride];
      end
      for (int m = 0; m < 4; m++) begin
         sr = 0;
         si = 0;
         for (int n = 0; n < 4; n++) begin
            rr = xr[n];
            ri = xi[n];
            for (int k = 0; k < (n * m) % 4; k++) begin
               t  = rr;  // rotate by -j
               rr = ri;
               ri = -t;
            end
            sr += rr;
            si += ri;
         end
         sr = sr >>> 2;
         si = si >>> 2;
         wr = twiddle_re(addr_w'((m * e) % n_points));
         wi = twiddle_im(addr_w'((m * e) % n_points));
         model_re[base + m * stride] = wrap_part((sr * wr - si * wi) >>> tw_frac);
         model_im[base + m * stride] = wrap_part((sr * wi + si * wr) >>> tw_frac);
      end
   endtask

   task automatic model_fft();
      for (int g = 0; g < 16; g++) begin
         model_group(g, 16, g);
      end
      for (int g = 0; g < 16; g++) begin
         model_group((g / 4) * 16 + g % 4, 4, 4 * (g % 4));
      end
      for (int g = 0; g < 16; g++) begin
         model_group(4 * g, 1, 0);
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failures found");
      $finish;
   endtask

   task automatic write_word(input logic [bus_aw-1:0] a, input logic [bus_dw-1:0] d);
      int wait_cnt;
      @(negedge clk);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = 1'b1;
      adr   = a;
      dat_w = d;
      wait_cnt = 0;
      @(negedge clk);
      while (!ack && wait_cnt < ack_timeout) begin
         @(negedge clk);
         wait_cnt++;
      end
      if (!ack) begin
         abort_run($sformatf("no ack for a write to address %0d", a));
      end else begin
         cyc = 1'b0;
         stb = 1'b0;
         we  = 1'b0;
      end
   endtask

   task automatic read_word(input logic [bus_aw-1:0] a, output logic [bus_dw-1:0] d);
      int wait_cnt;
      @(negedge clk);
      cyc = 1'b1;
      stb = 1'b1;
      we  = 1'b0;
      adr = a;
      wait_cnt = 0;
      @(negedge clk);
      while (!ack && wait_cnt < ack_timeout) begin
         @(negedge clk);
         wait_cnt++;
      end
      if (!ack) begin
         abort_run($sformatf("no ack for a read from address %0d", a));
      end else begin
         d   = dat_r;
         cyc = 1'b0;
         stb = 1'b0;
      end
   endtask

   task automatic wait_done();
      logic [bus_dw-1:0] st;
      int                polls;
      polls = 0;
      read_word(ctrl_addr, st);
      while (!st[1] && polls < done_timeout) begin
         read_word(ctrl_addr, st);
         polls++;
      end
      if (!st[1]) begin
         abort_run("the done bit was never set after a start");
      end
   endtask

   task automatic check_value(input string what, input logic [bus_dw-1:0] got,
                              input logic [bus_dw-1:0] expected);
      assert (got == expected) else begin
         $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got,
                  expected);
         test_errors++;
      end
   endtask

   // bus index n holds entry digit_rev(n)
   task automatic check_outputs(input string what);
      logic [bus_dw-1:0] got;
      for (int n = 0; n < n_points; n++) begin
         read_word(bus_aw'(n), got);
         check_value($sformatf("%s word %0d", what, n), got, model_word(digit_rev(addr_w'(n))));
      end
   endtask

   task automatic load_random_frame();
      logic [sample_w-1:0] s;
      for (int n = 0; n < n_points; n++) begin
         s = sample_w'(rand_bits(sample_w));
         set_model(n, s);
         write_word(bus_aw'(n), {10'd0, s});
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %0d, %s: ok", tests_run, name);
      end else begin
         $display("test %0d, %s: %0d errors", tests_run, name, test_errors);
         tests_failed++;
      end
      errors += test_errors;
      test_errors = 0;
   endtask

   initial begin
      logic [bus_dw-1:0]   got;
      logic [sample_w-1:0] s;
      clk   = 1'b0;
      rst   = 1'b0;
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      adr   = '0;
      dat_w = '0;
      lfsr  = 16'd56750;
      errors       = 0;
      test_errors  = 0;
      tests_run    = 0;
      tests_failed = 0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b1;

      read_word(ctrl_addr, got);
      check_value("status after reset", got, 32'd0);
      load_random_frame();
      check_outputs("readback");
      end_test("reset status and digit reversed readback");

      s = sample_w'(rand_bits(sample_w));
      for (int n = 0; n < n_points; n++) begin
         set_model(n, (n == 0) ? s : '0);
         write_word(bus_aw'(n), (n == 0) ? {10'd0, s} : 32'd0);
      end
      write_word(ctrl_addr, 32'd1);
      wait_done();
      model_fft();
      for (int n = 0; n < n_points; n++) begin  // flat spectrum scaled by 64
         check_value($sformatf("impulse model %0d", n), model_word(n),
                     pack_parts(wrap_part(int'(s[sample_w-1:part_w])) >>> 6,
                                wrap_part(int'(s[part_w-1:0])) >>> 6));
      end
      check_outputs("impulse");
      end_test("impulse response");

      for (int f = 0; f < 8; f++) begin
         load_random_frame();
         write_word(ctrl_addr, 32'd1);
         wait_done();
         read_word(ctrl_addr, got);
         check_value($sformatf("status after frame %0d", f), got, 32'd2);
         model_fft();
         check_outputs($sformatf("frame %0d", f));
      end
      end_test("eight random frames");

      load_random_frame();
      write_word(ctrl_addr, 32'd1);
      read_word(ctrl_addr, got);
      check_value("status while running", got, 32'd1);
      // group 15 of the first pass, still unread
      write_word({1'b0, 2'(rand_bits(2)), 4'hf}, rand_bits(bus_dw));
      write_word(ctrl_addr, 32'd1);
      wait_done();
      model_fft();
      check_outputs("writes while busy");
      end_test("writes ignored while busy");

      write_word(ctrl_addr, 32'd1);
      wait_done();
      model_fft();
      check_outputs("in place rerun");
      end_test("second transform of buffer contents");

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
rtl/fft64_pkg.sv
rtl/fft_wb_regs.sv
rtl/sample_buffer.sv
rtl/fft_sequencer.sv
rtl/radix4_butterfly.sv
rtl/fft64_top.sv
bench/fft64_tb.sv

/* Makefile */
sim := obj_dir/fft64_sim

.PHONY: run clean

run: $(sim)
	./$(sim) | tee sim.log
	grep -q "All tests passed!" sim.log

$(sim): sources.f $(wildcard rtl/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module fft64_tb \
		-f sources.f --Mdir obj_dir -o fft64_sim

clean:
	rm -rf obj_dir sim.log
